//--- Makefile
# Verilator build, run and lint of the timer testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = frc_timer_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = sim failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# A crash or a stopped assertion also counts as a failure
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/frc_timer_properties.sv
// Concurrent checks on the timer top level
// Bound into frc_timer, watches the read bus and the interrupt output

module frc_timer_properties (
  input logic                        PCLK,
  input logic                        PRESETn,
  input logic                        psel,
  input logic [frc_pkg::COUNT_W-1:0] prdata,
  input logic                        frc_int,
  input logic                        int_enable
);

  // --------------------------------------------------
  // Reset and bus
  // --------------------------------------------------
  // Interrupt output quiet in the first cycle out of reset
  reset_int_low: assert property (@(posedge PCLK) $rose(PRESETn) |-> !frc_int)
    else $error("frc_int high in the cycle after reset release");

  // Read bus parks at zero when not selected
  idle_read_zero: assert property (@(posedge PCLK) !psel |-> (prdata == '0))
    else $error("prdata not zero while psel is low");

  // --------------------------------------------------
  // Interrupt masking
  // --------------------------------------------------
  // No rising edge on frc_int with the enable clear
  mask_blocks_int: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !int_enable |-> !$rose(frc_int))
    else $error("frc_int rose while int_enable is clear");

endmodule

// Enable taken from the configuration link inside the top level
bind frc_timer frc_timer_properties i_properties (
  .PCLK       (PCLK),
  .PRESETn    (PRESETn),
  .psel       (psel),
  .prdata     (prdata),
  .frc_int    (frc_int),
  .int_enable (cfg.int_enable)
);

//--- bench/frc_timer_tb.sv
// Table-driven testbench for the free-running timer channel
// Applies APB writes, reads and waits from a table and checks readback and frc_int
// Random load values come from a Galois LFSR with a fixed seed

module frc_timer_tb;
  import frc_pkg::*;

  localparam logic [1:0] OP_WRITE    = 2'd0;
  localparam logic [1:0] OP_READ     = 2'd1;
  localparam logic [1:0] OP_WAIT     = 2'd2;
  localparam logic [1:0] OP_WAIT_INT = 2'd3;
  // Longest APB access in cycles
  localparam int ACCESS_CYCLES = 4;

  // data is write data, expected read, wait length or frc_int level
  typedef struct packed {
    logic [1:0]  kind;
    logic        clken;
    logic        bound;
    logic [2:0]  addr;
    logic [31:0] data;
    logic [15:0] limit;
  } op_t;

  logic               PCLK;
  logic               PRESETn;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [4:2]         paddr;
  logic [COUNT_W-1:0] pwdata;
  logic               timclken;
  logic [COUNT_W-1:0] prdata;
  logic               frc_int;

  op_t         ops[$];
  logic        cur_clken;
  logic [31:0] lfsr_q;
  int          max_wait;
  int          watchdog_cycles;
  logic        table_ready;
  int          checks;
  int          errors;

  frc_timer i_frc_timer (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .timclken (timclken),
    .prdata   (prdata),
    .frc_int  (frc_int)
  );

  // Period 20
  always #10 PCLK = ~PCLK;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // One step per bit taken
  task automatic rand_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      w[i]   = lfsr_q[0];
    end
  endtask

  function automatic logic [7:0] ctrl_byte(input logic en, input logic periodic,
                                           input logic ie, input logic [1:0] pre,
                                           input logic size32, input logic one_shot);
    frc_ctrl_u c;
    c.raw          = 8'h00;
    c.f.timer_en   = en;
    c.f.timer_mode = periodic;
    c.f.int_enable = ie;
    c.f.prescale   = pre;
    c.f.timer_size = size32;
    c.f.one_shot   = one_shot;
    return c.raw;
  endfunction

  function automatic string reg_name(input logic [2:0] addr);
    case (addr)
      3'd0:    return "load";
      3'd1:    return "value";
      3'd2:    return "control";
      3'd4:    return "ris";
      3'd5:    return "mis";
      3'd6:    return "bgload";
      default: return "prdata";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // Table entry with the current timclken level
  task automatic add_op(input logic [1:0] kind, input logic [2:0] addr,
                        input logic [31:0] data, input int limit, input logic bound);
    op_t op;
    op.kind  = kind;
    op.clken = cur_clken;
    op.bound = bound;
    op.addr  = addr;
    op.data  = data;
    op.limit = limit[15:0];
    ops.push_back(op);
    if (kind == OP_WAIT && int'(data) > max_wait)
      max_wait = int'(data);
    if (kind == OP_WAIT_INT && limit > max_wait)
      max_wait = limit;
  endtask

  // --------------------------------------------------
  // Bus tasks, each ends just after a rising edge
  // --------------------------------------------------
  task automatic apb_write(input logic [2:0] addr, input logic [31:0] data);
    @(posedge PCLK);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    penable <= 1'b0;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge PCLK);
    penable <= 1'b1;
    @(posedge PCLK);
    psel    <= 1'b0;
    pwrite  <= 1'b0;
    penable <= 1'b0;
  endtask

  // Read data sampled on the falling edge of the access phase
  task automatic apb_read(input logic [2:0] addr, output logic [31:0] data);
    @(posedge PCLK);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    penable <= 1'b0;
    paddr   <= addr;
    @(posedge PCLK);
    penable <= 1'b1;
    @(negedge PCLK);
    data = prdata;
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wait_for_int(input logic level, input int limit);
    int   cnt;
    logic seen;
    cnt  = 0;
    seen = 1'b0;
    while (!seen && cnt < limit)
    begin
      @(negedge PCLK);
      seen = (frc_int === level);
      cnt++;
    end
    @(posedge PCLK);
    if (!seen)
    begin
      errors++;
      $display("frc_int did not reach level %0d within %0d cycles", level, limit);
    end
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  task automatic build_table();
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    logic [31:0] rnd_c;
    rand_word(rnd_a);
    rand_word(rnd_b);
    rand_word(rnd_c);
    // Nonzero low half, so a load raises no zero carry
    rnd_a[0]  = 1'b1;
    rnd_c[0]  = 1'b1;
    cur_clken = 1'b1;
    // Reset state
    add_op(OP_READ, ADDR_CONTROL, 32'h0000_0020, 0, 0);
    add_op(OP_READ, ADDR_VALUE, 32'hFFFF_FFFF, 0, 0);
    add_op(OP_READ, ADDR_LOAD, 32'h0, 0, 0);
    add_op(OP_READ, ADDR_RIS, 32'h0, 0, 0);
    add_op(OP_READ, ADDR_MIS, 32'h0, 0, 0);
    // Load while disabled, background load leaves the count alone
    add_op(OP_WRITE, ADDR_LOAD, rnd_a, 0, 0);
    add_op(OP_READ, ADDR_LOAD, rnd_a, 0, 0);
    add_op(OP_READ, ADDR_VALUE, rnd_a, 0, 0);
    add_op(OP_WRITE, ADDR_BGLOAD, rnd_b, 0, 0);
    add_op(OP_READ, ADDR_LOAD, rnd_b, 0, 0);
    add_op(OP_READ, ADDR_BGLOAD, rnd_b, 0, 0);
    add_op(OP_READ, ADDR_VALUE, rnd_a, 0, 0);
    // One-shot, 32 bit, divide by 1
    add_op(OP_WRITE, ADDR_LOAD, 32'd5, 0, 0);
    add_op(OP_WRITE, ADDR_CONTROL, {24'h0, ctrl_byte(1, 0, 1, 2'b00, 1, 1)}, 0, 0);
    add_op(OP_READ, ADDR_CONTROL, {24'h0, ctrl_byte(1, 0, 1, 2'b00, 1, 1)}, 0, 0);
    add_op(OP_WAIT_INT, 3'd0, 32'd1, 40, 0);
    add_op(OP_READ, ADDR_VALUE, 32'h0, 0, 0);
    add_op(OP_WAIT, 3'd0, 32'd20, 0, 0);
    add_op(OP_READ, ADDR_VALUE, 32'h0, 0, 0);
    add_op(OP_READ, ADDR_RIS, 32'h1, 0, 0);
    add_op(OP_READ, ADDR_MIS, 32'h1, 0, 0);
    // Clear, then a masked expiry
    add_op(OP_WRITE, ADDR_CLEAR, 32'h0, 0, 0);
    add_op(OP_READ, ADDR_RIS, 32'h0, 0, 0);
    add_op(OP_READ, ADDR_MIS, 32'h0, 0, 0);
    add_op(OP_WRITE, ADDR_CONTROL, {24'h0, ctrl_byte(1, 0, 0, 2'b00, 1, 1)}, 0, 0);
    add_op(OP_WRITE, ADDR_LOAD, 32'd3, 0, 0);
    add_op(OP_WAIT, 3'd0, 32'd30, 0, 0);
    add_op(OP_READ, ADDR_RIS, 32'h1, 0, 0);
    add_op(OP_READ, ADDR_MIS, 32'h0, 0, 0);
    add_op(OP_WAIT_INT, 3'd0, 32'd0, 1, 0);
    // Periodic, 16 bit, divide by 16
    add_op(OP_WRITE, ADDR_CLEAR, 32'h0, 0, 0);
    add_op(OP_WRITE, ADDR_CONTROL, {24'h0, ctrl_byte(1, 1, 1, 2'b01, 0, 0)}, 0, 0);
    add_op(OP_WRITE, ADDR_LOAD, 32'd2, 0, 0);
    add_op(OP_WAIT_INT, 3'd0, 32'd1, 120, 0);
    add_op(OP_READ, ADDR_VALUE, 32'd2, 0, 1);
    add_op(OP_WRITE, ADDR_CLEAR, 32'h0, 0, 0);
    add_op(OP_WAIT_INT, 3'd0, 32'd0, 4, 0);
    add_op(OP_WAIT_INT, 3'd0, 32'd1, 120, 0);
    add_op(OP_READ, ADDR_VALUE, 32'd2, 0, 1);
    // Count frozen while timclken is low
    add_op(OP_WRITE, ADDR_CONTROL, {24'h0, ctrl_byte(0, 0, 1, 2'b00, 0, 0)}, 0, 0);
    add_op(OP_WRITE, ADDR_LOAD, rnd_c, 0, 0);
    add_op(OP_READ, ADDR_VALUE, rnd_c, 0, 0);
    cur_clken = 1'b0;
    add_op(OP_WRITE, ADDR_CONTROL, {24'h0, ctrl_byte(1, 0, 1, 2'b00, 1, 0)}, 0, 0);
    add_op(OP_WAIT, 3'd0, 32'd100, 0, 0);
    add_op(OP_READ, ADDR_VALUE, rnd_c, 0, 0);
    add_op(OP_READ, ADDR_LOAD, rnd_c, 0, 0);
    cur_clken = 1'b1;
    add_op(OP_WAIT, 3'd0, 32'd4, 0, 0);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial
  begin
    logic [31:0] rdata;
    PCLK        = 1'b0;
    PRESETn     = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = 3'd0;
    pwdata      = '0;
    timclken    = 1'b1;
    lfsr_q      = 32'd87;
    max_wait    = ACCESS_CYCLES;
    checks      = 0;
    errors      = 0;
    table_ready = 1'b0;
    build_table();
    watchdog_cycles = ops.size() * max_wait + 200;
    table_ready     = 1'b1;
    repeat (2) @(posedge PCLK);
    PRESETn <= 1'b1;
    foreach (ops[i])
    begin
      timclken <= ops[i].clken;
      case (ops[i].kind)
        OP_WRITE: apb_write(ops[i].addr, ops[i].data);
        OP_READ:
        begin
          apb_read(ops[i].addr, rdata);
          // Bound entries only require value <= the load
          if (ops[i].bound)
            check_value("value_le_load", {31'b0, rdata <= ops[i].data}, 32'd1);
          else
            check_value(reg_name(ops[i].addr), rdata, ops[i].data);
        end
        OP_WAIT: repeat (ops[i].data) @(posedge PCLK);
        default: wait_for_int(ops[i].data[0], int'(ops[i].limit));
      endcase
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Watchdog sized from the table
  initial
  begin
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge PCLK);
    $display("timeout after %0d cycles, the table did not complete", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

//--- sim.f
source/frc_pkg.sv
source/frc_cfg_if.sv
source/frc_apb_regs.sv
source/frc_prescaler.sv
source/frc_counter.sv
source/frc_irq.sv
source/frc_timer.sv
bench/frc_timer_properties.sv
bench/frc_timer_tb.sv

//--- source/frc_apb_regs.sv
// APB register stage of the timer channel
// Decodes setup-phase writes into control, load and period registers,
// pulses the load and clear strobes and muxes the read data

module frc_apb_regs (
  input  logic                       PCLK,
  input  logic                       PRESETn,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [4:2]                 paddr,
  input  logic [frc_pkg::COUNT_W-1:0] pwdata,
  input  logic [frc_pkg::COUNT_W-1:0] count_read,
  input  logic                       raw_int,
  input  logic                       masked_int,
  output logic [frc_pkg::COUNT_W-1:0] prdata,
  output logic                       clr_strobe,
  frc_cfg_if.regs                    cfg
);
  import frc_pkg::*;

  logic               wr_setup;
  logic               ctrl_wr;
  logic               load_wr;
  logic               bgload_wr;
  logic               clr_wr;
  frc_ctrl_u          ctrl_q;
  frc_ctrl_u          ctrl_wdata;
  logic [COUNT_W-1:0] load_val_q;
  logic [COUNT_W-1:0] load_period_q;
  logic               load_strobe_q;

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------
  // Writes are taken in the setup phase
  assign wr_setup  = psel & pwrite & ~penable;
  assign ctrl_wr   = wr_setup & (paddr == ADDR_CONTROL);
  assign load_wr   = wr_setup & (paddr == ADDR_LOAD);
  assign bgload_wr = wr_setup & (paddr == ADDR_BGLOAD);
  assign clr_wr    = wr_setup & (paddr == ADDR_CLEAR);

  // Bit 4 is not implemented
  always_comb
  begin
    ctrl_wdata.raw    = pwdata[7:0];
    ctrl_wdata.f.rsvd = 1'b0;
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      ctrl_q.raw    <= CTRL_RESET;
      load_period_q <= '0;
      load_strobe_q <= 1'b0;
      clr_strobe    <= 1'b0;
    end
    else
    begin
      if (ctrl_wr)
        ctrl_q <= ctrl_wdata;
      // Both load kinds set the next wrap value
      if (load_wr | bgload_wr)
        load_period_q <= pwdata;
      load_strobe_q <= load_wr;
      clr_strobe    <= clr_wr;
    end
  end

  // Only a direct load replaces the count
  always_ff @(posedge PCLK)
  begin
    if (load_wr)
      load_val_q <= pwdata;
  end

  // Fields out to the timer stages
  assign cfg.timer_en    = ctrl_q.f.timer_en;
  assign cfg.timer_mode  = ctrl_q.f.timer_mode;
  assign cfg.int_enable  = ctrl_q.f.int_enable;
  assign cfg.prescale    = ctrl_q.f.prescale;
  assign cfg.timer_size  = ctrl_q.f.timer_size;
  assign cfg.one_shot    = ctrl_q.f.one_shot;
  assign cfg.load_strobe = load_strobe_q;
  assign cfg.load_val    = load_val_q;
  assign cfg.load_period = load_period_q;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  // Zero when not selected for a read
  always_comb
  begin
    prdata = '0;
    if (psel & ~pwrite)
    begin
      case (paddr)
        // Load and background load both return the period
        ADDR_LOAD:    prdata = load_period_q;
        ADDR_BGLOAD:  prdata = load_period_q;
        ADDR_VALUE:   prdata = count_read;
        ADDR_CONTROL: prdata[7:0] = ctrl_q.raw;
        ADDR_RIS:     prdata[0] = raw_int;
        ADDR_MIS:     prdata[0] = masked_int;
        default:      prdata = '0;
      endcase
    end
  end

endmodule

//--- source/frc_cfg_if.sv
// Configuration link from the register stage to the timer stages
// Carries the decoded control fields, the load values and the load strobe
// The register stage drives it, the other stages read their own subset

interface frc_cfg_if;
  import frc_pkg::*;

  // Control fields
  logic               timer_en;
  logic               timer_mode;
  logic               int_enable;
  logic [1:0]         prescale;
  logic               timer_size;
  logic               one_shot;

  // One-cycle pulse after a load write
  logic               load_strobe;
  // Value applied on the next load
  logic [COUNT_W-1:0] load_val;
  // Reload value on periodic wrap
  logic [COUNT_W-1:0] load_period;

  modport regs (
    output timer_en, timer_mode, int_enable, prescale, timer_size, one_shot,
    output load_strobe, load_val, load_period
  );

  modport prescaler (input timer_en, prescale, load_strobe);

  modport counter (
    input timer_en, timer_mode, timer_size, one_shot, load_val, load_period
  );

  modport irq (input int_enable);

endinterface

//--- source/frc_counter.sv
// Down-counter of the timer channel, 16 or 32 bits
// Two half-words with registered carries, periodic reload and one-shot stop
// Steps on count_tick, loads on load_go

module frc_counter (
  input  logic                        PCLK,
  input  logic                        PRESETn,
  input  logic                        load_go,
  input  logic                        count_tick,
  input  logic                        load_pending,
  frc_cfg_if.counter                  cfg,
  output logic                        carry_msb,
  output logic [frc_pkg::COUNT_W-1:0] count_read
);
  import frc_pkg::*;

  logic [COUNT_W-1:0] count_q;
  logic [COUNT_W-1:0] count_nxt;
  logic [COUNT_W-1:0] reload_val;
  logic [1:0]         carry_q;
  logic [HALF_W-1:0]  low_dec;
  logic [HALF_W-1:0]  high_dec;
  logic [HALF_W-1:0]  high_src;
  logic               carry0_nxt;
  logic               carry1_nxt;
  logic               reload;
  logic               stop_q;
  logic               stop_now;
  logic               update;

  // Carry of the active size marks count zero
  assign carry_msb = cfg.timer_size ? carry_q[1] : carry_q[0];

  // Reload on a load, or on wrap in periodic mode
  assign reload     = load_go | (carry_msb & cfg.timer_mode);
  assign reload_val = load_go ? cfg.load_val : cfg.load_period;

  // --------------------------------------------------
  // One-shot stop
  // --------------------------------------------------
  // Released by a new load or by leaving one-shot mode
  always_comb
  begin
    if (load_go | ~cfg.one_shot)
      stop_now = 1'b0;
    else if (carry_msb)
      stop_now = 1'b1;
    else
      stop_now = stop_q;
  end

  assign update = (count_tick & cfg.timer_en & ~stop_now) | load_go;

  // --------------------------------------------------
  // Next count and carries
  // --------------------------------------------------
  assign low_dec = count_q[HALF_W-1:0] - 1'b1;

  // Upper half steps only in 32-bit mode, when the lower half wraps
  assign high_dec = (cfg.timer_size & carry_q[0]) ?
                    count_q[COUNT_W-1:HALF_W] - 1'b1 : count_q[COUNT_W-1:HALF_W];

  assign carry0_nxt = reload ? (reload_val[HALF_W-1:0] == '0) :
                               (count_q[HALF_W-1:0] == 16'h0001);

  assign high_src = reload ? reload_val[COUNT_W-1:HALF_W] : count_q[COUNT_W-1:HALF_W];

  // Upper carry follows the lower one in 16-bit mode so a size change is quiet
  always_comb
  begin
    if (~cfg.timer_size)
      carry1_nxt = carry0_nxt;
    else
      carry1_nxt = carry0_nxt & ~carry_msb & (high_src == '0);
  end

  // Load first, then periodic reload, then decrement
  always_comb
  begin
    if (load_go)
      count_nxt = cfg.load_val;
    else if (carry_msb & cfg.timer_mode)
      count_nxt = cfg.load_period;
    else
      count_nxt = {high_dec, low_dec};
  end

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      count_q <= COUNT_RESET;
      carry_q <= 2'b00;
      stop_q  <= 1'b0;
    end
    else
    begin
      stop_q <= stop_now;
      if (update)
      begin
        count_q <= count_nxt;
        carry_q <= {carry1_nxt, carry0_nxt};
      end
    end
  end

  // Show the new value as soon as a load is requested
  assign count_read = load_pending ? cfg.load_val : count_q;

endmodule

//--- source/frc_irq.sv
// Interrupt stage of the timer channel
// Raw interrupt set at count zero, clear held until the counter leaves zero

module frc_irq (
  input  logic    PCLK,
  input  logic    PRESETn,
  input  logic    timclken,
  input  logic    carry_msb,
  input  logic    clr_strobe,
  frc_cfg_if.irq  cfg,
  output logic    raw_int,
  output logic    masked_int
);

  logic raw_q;
  logic clr_q;
  logic clr_now;

  // Clear active from the strobe cycle onwards
  assign clr_now = clr_strobe | clr_q;

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      raw_q <= 1'b0;
      clr_q <= 1'b0;
    end
    else
    begin
      // One zero event gives one interrupt
      if (clr_strobe)
        clr_q <= 1'b1;
      else if (timclken & ~carry_msb)
        clr_q <= 1'b0;
      if (timclken)
        raw_q <= (carry_msb | raw_q) & ~clr_now;
    end
  end

  // Readback shows the clear at once
  assign raw_int    = raw_q & ~clr_now;
  assign masked_int = raw_int & cfg.int_enable;

endmodule

//--- source/frc_pkg.sv
// Shared definitions for the free-running timer channel
// Register offsets on paddr[4:2], widths, reset values and the control byte
// Import inside a module body, or use scoped names in a port list

package frc_pkg;

  // --------------------------------------------------
  // Register word offsets
  // --------------------------------------------------
  localparam logic [2:0] ADDR_LOAD    = 3'd0;
  localparam logic [2:0] ADDR_VALUE   = 3'd1;
  localparam logic [2:0] ADDR_CONTROL = 3'd2;
  localparam logic [2:0] ADDR_CLEAR   = 3'd3;
  localparam logic [2:0] ADDR_RIS     = 3'd4;
  localparam logic [2:0] ADDR_MIS     = 3'd5;
  localparam logic [2:0] ADDR_BGLOAD  = 3'd6;

  // Counter, half-word and prescaler widths
  localparam int COUNT_W    = 32;
  localparam int HALF_W     = 16;
  localparam int PRESCALE_W = 8;

  // Interrupt enable set, everything else clear
  localparam logic [7:0] CTRL_RESET = 8'h20;
  // All ones so no interrupt fires straight out of reset
  localparam logic [COUNT_W-1:0] COUNT_RESET = '1;

  // Control byte seen as named fields
  typedef struct packed {
    logic       timer_en;
    logic       timer_mode;
    logic       int_enable;
    logic       rsvd;
    logic [1:0] prescale;
    logic       timer_size;
    logic       one_shot;
  } frc_ctrl_s;

  // Control byte seen as the raw bus byte or as fields
  typedef union packed {
    logic [7:0] raw;
    frc_ctrl_s  f;
  } frc_ctrl_u;

endpackage

//--- source/frc_prescaler.sv
// Clock-enable stage of the timer channel
// Holds the pending load and the prescale counter, issues load and count strobes

module frc_prescaler (
  input  logic           PCLK,
  input  logic           PRESETn,
  input  logic           timclken,
  frc_cfg_if.prescaler   cfg,
  output logic           load_go,
  output logic           count_tick,
  output logic           load_pending
);
  import frc_pkg::*;

  logic [PRESCALE_W-1:0] pre_cnt;
  logic                  div_term;

  // Load waits for the next enabled edge
  assign load_go = load_pending & timclken;

  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      load_pending <= 1'b0;
      pre_cnt      <= '0;
    end
    else
    begin
      // New request wins over the one being applied
      if (cfg.load_strobe)
        load_pending <= 1'b1;
      else if (timclken)
        load_pending <= 1'b0;
      // Restart the divider so the first period is full length
      if (load_go)
        pre_cnt <= '0;
      else if (timclken & cfg.timer_en)
        pre_cnt <= pre_cnt - 1'b1;
    end
  end

  // Divider select, 2'b11 behaves as divide by 1
  always_comb
  begin
    case (cfg.prescale)
      2'b01:   div_term = (pre_cnt[3:0] == 4'h1);
      2'b10:   div_term = (pre_cnt == 8'h01);
      default: div_term = 1'b1;
    endcase
  end

  assign count_tick = timclken & cfg.timer_en & div_term;

endmodule

//--- source/frc_timer.sv
// Top level of the single-channel free-running timer
// APB-style register port, counter clocked on PCLK and stepped by timclken
// Instances and wiring only

module frc_timer (
  input  logic                        PCLK,
  input  logic                        PRESETn,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [4:2]                  paddr,
  input  logic [frc_pkg::COUNT_W-1:0] pwdata,
  input  logic                        timclken,
  output logic [frc_pkg::COUNT_W-1:0] prdata,
  output logic                        frc_int
);
  import frc_pkg::*;

  // Stage links
  logic               load_go;
  logic               count_tick;
  logic               load_pending;
  logic               carry_msb;
  logic [COUNT_W-1:0] count_read;
  logic               clr_strobe;
  logic               raw_int;

  frc_cfg_if cfg ();

  frc_apb_regs i_regs (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .count_read (count_read),
    .raw_int    (raw_int),
    .masked_int (frc_int),
    .prdata     (prdata),
    .clr_strobe (clr_strobe),
    .cfg        (cfg.regs)
  );

  frc_prescaler i_prescaler (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .timclken     (timclken),
    .cfg          (cfg.prescaler),
    .load_go      (load_go),
    .count_tick   (count_tick),
    .load_pending (load_pending)
  );

  frc_counter i_counter (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .load_go      (load_go),
    .count_tick   (count_tick),
    .load_pending (load_pending),
    .cfg          (cfg.counter),
    .carry_msb    (carry_msb),
    .count_read   (count_read)
  );

  // Masked interrupt is the channel output
  frc_irq i_irq (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .timclken   (timclken),
    .carry_msb  (carry_msb),
    .clr_strobe (clr_strobe),
    .cfg        (cfg.irq),
    .raw_int    (raw_int),
    .masked_int (frc_int)
  );

endmodule
